// ==== seg_pkg.sv ====
// shared register map, display modes and hex glyph decoder for the seven-segment controller
`default_nettype none

package seg_pkg;

    localparam int w_seg = 8; // segments a..g plus the point

    // APB byte addresses of the three registers
    typedef enum logic [7:0] {
        reg_number = 8'h00, // packed hex nibbles, digit 0 in the low nibble
        reg_dots   = 8'h04, // one point bit per digit
        reg_ctrl   = 8'h08  // display mode
    } seg_addr_t;

    // code 2'd3 is not named and blanks the display like mode_off
    typedef enum logic [1:0] {
        mode_off    = 2'd0,
        mode_on     = 2'd1,
        mode_on_low = 2'd2 // common-anode boards
    } seg_mode_t;

    // bit 7 is segment a, bit 1 is g, bit 0 (point) stays clear
    function automatic logic [w_seg - 1:0] hex_to_seg(input logic [3:0] nibble);
        case (nibble)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1110_0110;
            4'ha:    return 8'b1110_1110;
            4'hb:    return 8'b0011_1110; // lower case b
            4'hc:    return 8'b1001_1100;
            4'hd:    return 8'b0111_1010; // lower case d
            4'he:    return 8'b1001_1110;
            default: return 8'b1000_1110; // F
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== seg_apb_regs.sv ====
// APB slave with the number, dots and control registers feeding the digit scanner
`timescale 1ns/1ps
`default_nettype none

module seg_apb_regs #(
    parameter int w_digit = 4
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic [7:0]             paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,

    output logic [w_digit * 4 - 1:0] number,
    output logic [w_digit - 1:0]     dots,
    output seg_pkg::seg_mode_t       mode
);

    import seg_pkg::*;

    logic        access;   // second phase of a transfer
    logic        write_en;
    logic        addr_ok;
    logic [31:0] rdata;

    assign access   = psel & penable;
    assign write_en = access & pwrite;

    // address decode and read mux
    always_comb begin
        addr_ok = 1'b1;
        rdata   = '0;
        case (paddr)
            reg_number: rdata[w_digit * 4 - 1:0] = number;
            reg_dots:   rdata[w_digit - 1:0]     = dots;
            reg_ctrl:   rdata[1:0]               = mode;
            default:    addr_ok                  = 1'b0;
        endcase
    end

    assign prdata  = rdata;           // zero for unmapped addresses
    assign pready  = access;          // never any wait states
    assign pslverr = access & ~addr_ok;

    // register writes land at the edge closing the access phase
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            number <= '0;
            dots   <= '0;
            mode   <= mode_off;
        end else if (write_en) begin
            case (paddr)
                reg_number: number <= pwdata[w_digit * 4 - 1:0];
                reg_dots:   dots   <= pwdata[w_digit - 1:0];
                reg_ctrl:   mode   <= seg_mode_t'(pwdata[1:0]);
                default: ; // unmapped, dropped silently apart from pslverr
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== seg_refresh_timer.sv ====
// free-running dividers that pace the display latch update and the digit scan
`timescale 1ns/1ps
`default_nettype none

module seg_refresh_timer #(
    parameter int update_cycles = 12_500_000,
    parameter int scan_cycles   = 50_000
) (
    input  logic clk,
    input  logic rst,
    output logic update_tick,
    output logic scan_tick
);

    // counter widths, at least one bit even for a period of one
    localparam int w_update = (update_cycles > 1) ? $clog2(update_cycles) : 1;
    localparam int w_scan   = (scan_cycles > 1) ? $clog2(scan_cycles) : 1;

    localparam logic [w_update - 1:0] update_last = w_update'(update_cycles - 1);
    localparam logic [w_scan - 1:0]   scan_last   = w_scan'(scan_cycles - 1);

    logic [w_update - 1:0] update_cnt;
    logic [w_scan - 1:0]   scan_cnt;

    // tick sits on the terminal count, one cycle wide
    assign update_tick = (update_cnt == update_last);
    assign scan_tick   = (scan_cnt == scan_last);

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            update_cnt <= '0;
        else if (update_tick)
            update_cnt <= '0;
        else
            update_cnt <= update_cnt + 1'b1;
    end

    // scan period is independent of the update divider
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            scan_cnt <= '0;
        else if (scan_tick)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

endmodule

`default_nettype wire

// ==== seg_digit_scan.sv ====
// display latch and digit multiplexer driving registered segment and digit-enable pins
`timescale 1ns/1ps
`default_nettype none

module seg_digit_scan #(
    parameter int w_digit = 4
) (
    input  logic                       clk,
    input  logic                       rst,

    input  logic [w_digit * 4 - 1:0]   number,
    input  logic [w_digit - 1:0]       dots,
    input  seg_pkg::seg_mode_t         mode,
    input  logic                       update_tick,
    input  logic                       scan_tick,

    output logic [seg_pkg::w_seg - 1:0] abcdefgh,
    output logic [w_digit - 1:0]        digit
);

    import seg_pkg::*;

    localparam int w_index = (w_digit > 1) ? $clog2(w_digit) : 1;
    localparam logic [w_index - 1:0] index_last = w_index'(w_digit - 1);

    logic [w_digit * 4 - 1:0] number_latch; // what the pins show
    logic [w_digit - 1:0]     dots_latch;
    logic [w_index - 1:0]     index;        // active digit

    logic [3:0]           nibble;
    logic [w_seg - 1:0]   seg_word;
    logic [w_digit - 1:0] digit_word;
    logic [w_seg - 1:0]   seg_next;
    logic [w_digit - 1:0] digit_next;

    // latch refreshes only on the slow tick so a host write never tears the display
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            number_latch <= '0;
            dots_latch   <= '0;
        end else if (update_tick) begin
            number_latch <= number;
            dots_latch   <= dots;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            index <= '0;
        else if (scan_tick)
            index <= (index == index_last) ? '0 : index + 1'b1;
    end

    // decode of the active digit
    always_comb begin
        nibble      = number_latch[index * 4 +: 4];
        seg_word    = hex_to_seg(nibble);
        seg_word[0] = dots_latch[index]; // point segment
        digit_word  = w_digit'(1) << index;
    end

    // polarity and blanking
    always_comb begin
        case (mode)
            mode_on: begin
                seg_next   = seg_word;
                digit_next = digit_word;
            end
            mode_on_low: begin
                seg_next   = ~seg_word;
                digit_next = ~digit_word;
            end
            default: begin // mode_off and the spare code
                seg_next   = '0;
                digit_next = '0;
            end
        endcase
    end

    // pins lag the scanner state by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            abcdefgh <= '0;
            digit    <= '0;
        end else begin
            abcdefgh <= seg_next;
            digit    <= digit_next;
        end
    end

endmodule

`default_nettype wire

// ==== seg_display_top.sv ====
// top of the APB seven-segment controller, sets timing parameters for the submodules
`timescale 1ns/1ps
`default_nettype none

module seg_display_top #(
    parameter int w_digit       = 4,
    parameter int update_cycles = 12_500_000, // latch refresh period in clocks
    parameter int scan_cycles   = 50_000      // clocks spent on each digit
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic [7:0]                  paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,

    output logic [seg_pkg::w_seg - 1:0] abcdefgh,
    output logic [w_digit - 1:0]        digit
);

    import seg_pkg::*;

    logic [w_digit * 4 - 1:0] number;
    logic [w_digit - 1:0]     dots;
    seg_mode_t                mode;
    logic                     update_tick;
    logic                     scan_tick;

    seg_apb_regs #(
        .w_digit (w_digit)
    ) seg_apb_regs_inst (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .number  (number),
        .dots    (dots),
        .mode    (mode)
    );

    seg_refresh_timer #(
        .update_cycles (update_cycles),
        .scan_cycles   (scan_cycles)
    ) seg_refresh_timer_inst (
        .clk         (clk),
        .rst         (rst),
        .update_tick (update_tick),
        .scan_tick   (scan_tick)
    );

    seg_digit_scan #(
        .w_digit (w_digit)
    ) seg_digit_scan_inst (
        .clk         (clk),
        .rst         (rst),
        .number      (number),
        .dots        (dots),
        .mode        (mode),
        .update_tick (update_tick),
        .scan_tick   (scan_tick),
        .abcdefgh    (abcdefgh),
        .digit       (digit)
    );

endmodule

`default_nettype wire

// ==== tb_seg_clock.sv ====
// clock and reset source for the seven-segment testbench, 4 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_seg_clock #(
    parameter int half_ns      = 2,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(half_ns) clk = ~clk;
    end

    // release lands just after a rising edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb_seg_display.sv ====
// testbench for seg_display_top, random APB traffic checked against a cycle model
`timescale 1ns/1ps
`default_nettype none

module tb_seg_display;

    import seg_pkg::*;

    localparam int w_digit       = 4;
    localparam int update_cycles = 24;
    localparam int scan_cycles   = 3;

    localparam int n_reg   = 24; // write/read pairs on mapped registers
    localparam int n_bad   = 8;  // unmapped address probes
    localparam int n_hex   = 16;
    localparam int obs_hex = 30;
    localparam int n_pol   = 6;
    localparam int obs_pol = 30;
    localparam int n_xfer  = 3 + n_reg * 2 + n_bad * 5 + 1 + n_hex * 2 + n_pol * 2;
    localparam int n_obs   = n_hex * obs_hex + n_pol * obs_pol;
    localparam int timeout_ns = (n_xfer * 2 + n_obs * 2 + 100) * 4;

    // mode sequence for the polarity test, entry 0 in the low bits
    localparam logic [11:0] pol_seq = {2'd1, 2'd2, 2'd3, 2'd0, 2'd2, 2'd1};

    logic                 clk;
    logic                 rst;
    logic [7:0]           paddr;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [31:0]          pwdata;
    logic [31:0]          prdata;
    logic                 pready;
    logic                 pslverr;
    logic [w_seg - 1:0]   abcdefgh;
    logic [w_digit - 1:0] digit;

    // model state
    logic [w_digit * 4 - 1:0] m_number;
    logic [w_digit - 1:0]     m_dots;
    seg_mode_t                m_mode;
    logic [w_digit * 4 - 1:0] m_num_latch;
    logic [w_digit - 1:0]     m_dot_latch;
    int                       m_upd_cnt;
    int                       m_scan_cnt;
    int                       m_index;
    logic [w_seg - 1:0]       m_seg;
    logic [w_digit - 1:0]     m_digit;

    integer seed = 57;

    tb_seg_clock clock_gen (
        .clk (clk),
        .rst (rst)
    );

    seg_display_top #(
        .w_digit       (w_digit),
        .update_cycles (update_cycles),
        .scan_cycles   (scan_cycles)
    ) seg_display_top_inst (
        .clk      (clk),
        .rst      (rst),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    task automatic report_failure();
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_seg(input logic [w_seg - 1:0] act, input logic [w_seg - 1:0] exp);
        if (act !== exp) begin
            $display("[ERROR] %0t ns abcdefgh expected %h got %h", $time, exp, act);
            report_failure();
        end
    endtask

    task automatic check_digit(input logic [w_digit - 1:0] act, input logic [w_digit - 1:0] exp);
        if (act !== exp) begin
            $display("[ERROR] %0t ns digit expected %b got %b", $time, exp, act);
            report_failure();
        end
    endtask

    task automatic check_mode(input seg_mode_t act, input seg_mode_t exp);
        if (act !== exp) begin
            $display("[ERROR] %0t ns mode expected %0d got %0d", $time, exp, act);
            report_failure();
        end
    endtask

    task automatic check_data(input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("[ERROR] %0t ns prdata expected %h got %h", $time, exp, act);
            report_failure();
        end
    endtask

    task automatic check_err(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("[ERROR] %0t ns %s expected %b got %b", $time, name, exp, act);
            report_failure();
        end
    endtask

    // bits of pwdata a register keeps, zero for unmapped addresses
    function automatic logic [31:0] field_mask(input logic [7:0] addr);
        logic [31:0] mask;
        mask = '0;
        case (addr)
            reg_number: mask[w_digit * 4 - 1:0] = '1;
            reg_dots:   mask[w_digit - 1:0]     = '1;
            reg_ctrl:   mask[1:0]               = 2'b11;
            default: ;
        endcase
        return mask;
    endfunction

    function automatic logic [w_seg - 1:0] model_seg(input seg_mode_t md,
            input logic [w_digit * 4 - 1:0] num, input logic [w_digit - 1:0] dts,
            input int idx);
        logic [w_seg - 1:0] word;
        word    = hex_to_seg(num[idx * 4 +: 4]);
        word[0] = dts[idx];
        case (md)
            mode_on:     return word;
            mode_on_low: return ~word;
            default:     return '0;
        endcase
    endfunction

    function automatic logic [w_digit - 1:0] model_digit(input seg_mode_t md, input int idx);
        logic [w_digit - 1:0] hot;
        hot      = '0;
        hot[idx] = 1'b1;
        case (md)
            mode_on:     return hot;
            mode_on_low: return ~hot;
            default:     return '0;
        endcase
    endfunction

    // cycle model of registers, timer, latch, index and output stage
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m_number    <= '0;
            m_dots      <= '0;
            m_mode      <= mode_off;
            m_num_latch <= '0;
            m_dot_latch <= '0;
            m_upd_cnt   <= 0;
            m_scan_cnt  <= 0;
            m_index     <= 0;
            m_seg       <= '0;
            m_digit     <= '0;
        end else begin
            if (psel && penable && pwrite) begin
                case (paddr)
                    reg_number: m_number <= pwdata[w_digit * 4 - 1:0];
                    reg_dots:   m_dots   <= pwdata[w_digit - 1:0];
                    reg_ctrl:   m_mode   <= seg_mode_t'(pwdata[1:0]);
                    default: ;
                endcase
            end
            m_upd_cnt  <= (m_upd_cnt == update_cycles - 1) ? 0 : m_upd_cnt + 1;
            m_scan_cnt <= (m_scan_cnt == scan_cycles - 1) ? 0 : m_scan_cnt + 1;
            if (m_upd_cnt == update_cycles - 1) begin
                m_num_latch <= m_number;
                m_dot_latch <= m_dots;
            end
            if (m_scan_cnt == scan_cycles - 1)
                m_index <= (m_index == w_digit - 1) ? 0 : m_index + 1;
            m_seg   <= model_seg(m_mode, m_num_latch, m_dot_latch, m_index);
            m_digit <= model_digit(m_mode, m_index);
        end
    end

    // pins compared every cycle after the first clock edge, reset included
    always @(negedge clk) begin
        if ($time > 0) begin
            check_seg(abcdefgh, m_seg);
            check_digit(digit, m_digit);
        end
    end

    initial begin
        #(timeout_ns);
        $display("timeout: the test sequence did not finish in %0d ns", timeout_ns);
        report_failure();
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // setup then access phase, response sampled mid access cycle
    task automatic bus_transfer(input logic [7:0] addr, input logic wr,
            input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        check_err("pready", pready, 1'b1);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata,
            input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        bus_transfer(addr, 1'b1, wdata, rdata, err);
        check_err("pslverr", err, exp_err);
    endtask

    task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp,
            input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        bus_transfer(addr, 1'b0, 32'h0, rdata, err);
        if (addr == reg_ctrl)
            check_mode(seg_mode_t'(rdata[1:0]), seg_mode_t'(exp[1:0]));
        check_data(rdata, exp);
        check_err("pslverr", err, exp_err);
    endtask

    initial begin : main
        logic [31:0] wdata;
        logic [7:0]  addr;
        int          i;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        @(negedge rst);

        // reset values
        read_expect(reg_number, 32'h0, 1'b0);
        read_expect(reg_dots, 32'h0, 1'b0);
        read_expect(reg_ctrl, 32'(mode_off), 1'b0);

        for (i = 0; i < n_reg; i++) begin
            case ($unsigned($random(seed)) % 3)
                0:       addr = reg_number;
                1:       addr = reg_dots;
                default: addr = reg_ctrl;
            endcase
            wdata = $random(seed);
            write_reg(addr, wdata, 1'b0);
            read_expect(addr, wdata & field_mask(addr), 1'b0);
        end

        // unmapped addresses must leave the mapped registers alone
        for (i = 0; i < n_bad; i++) begin
            addr = reg_number;
            while (field_mask(addr) != 32'h0)
                addr = $random(seed);
            write_reg(addr, $random(seed), 1'b1);
            read_expect(addr, 32'h0, 1'b1);
            read_expect(reg_number, 32'(m_number), 1'b0);
            read_expect(reg_dots, 32'(m_dots), 1'b0);
            read_expect(reg_ctrl, 32'(m_mode), 1'b0);
        end

        write_reg(reg_ctrl, 32'(mode_on), 1'b0);
        for (i = 0; i < n_hex; i++) begin
            write_reg(reg_number, $random(seed), 1'b0);
            write_reg(reg_dots, $random(seed), 1'b0);
            wait_cycles(obs_hex);
        end

        // polarity, blanking and the spare mode code
        for (i = 0; i < n_pol; i++) begin
            write_reg(reg_ctrl, 32'(pol_seq[i * 2 +: 2]), 1'b0);
            read_expect(reg_ctrl, 32'(pol_seq[i * 2 +: 2]), 1'b0);
            wait_cycles(obs_pol);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== seg_display.f ====
seg_pkg.sv
seg_apb_regs.sv
seg_refresh_timer.sv
seg_digit_scan.sv
seg_display_top.sv
tb_seg_clock.sv
tb_seg_display.sv
